// ==== rtl/pma_defs.svh ====
// Build-time PMA sizing only. Region count must match the length of PMA_CFG in pma_pkg
`ifndef PMA_DEFS_SVH
`define PMA_DEFS_SVH

//////////////////////////////
// Region table size
//////////////////////////////

// Number of entries in the fixed region table
// Zero selects the deconfigured build, which treats all memory as main
`define PMA_NUM_REGIONS 4

//////////////////////////////
// Core features
//////////////////////////////

// Atomic extension present
// When cleared every atomic access faults, whatever the region says
`define PMA_A_EXTENSION 1'b1

//////////////////////////////
// Fault counter
//////////////////////////////

// Width of the saturating fault counter
// Counter holds at all ones once reached
`define PMA_ERR_CNT_W 8

`endif

// ==== rtl/pma_pkg.sv ====
// Regions are fixed at elaboration and use word addresses with an exclusive upper bound
`include "pma_defs.svh"

package pma_pkg;

  //////////////////////////////
  // Request encodings
  //////////////////////////////

  typedef enum logic [1:0] {
    ACC_FETCH = 2'd0,
    ACC_LOAD  = 2'd1,
    ACC_STORE = 2'd2
  } access_kind_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  // One attribute region, low bound inclusive
  typedef struct packed {
    logic [31:0] word_addr_low;
    logic [31:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        atomic;
  } pma_region_t;

  // Access as seen after the decode stage
  typedef struct packed {
    logic [31:0] word_addr;
    logic        fetch;
    logic        load;
    logic        atomic;
    logic        misaligned;
  } pma_access_t;

  // Execute stage result, fault reasons kept separate
  typedef struct packed {
    logic       err_atomic;
    logic       err_fetch;
    logic       err_misaligned;
    logic       bufferable;
    logic       cacheable;
    logic       hit;
    logic [1:0] region;
  } pma_attr_t;

  //////////////////////////////
  // Response encodings
  //////////////////////////////

  typedef enum logic [1:0] {
    CAUSE_NONE       = 2'd0,
    CAUSE_ATOMIC     = 2'd1,
    CAUSE_FETCH      = 2'd2,
    CAUSE_MISALIGNED = 2'd3
  } pma_cause_e;

  typedef struct packed {
    logic       err;
    pma_cause_e cause;
    logic       bufferable;
    logic       cacheable;
    logic       hit;
    logic [1:0] region;
  } pma_rsp_t;

  //////////////////////////////
  // Attribute constants
  //////////////////////////////

  // Unmatched address is treated as I/O with no special attributes
  localparam pma_region_t PMA_R_DEFAULT = '{
    word_addr_low: 32'h0, word_addr_high: 32'h0,
    main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0
  };

  // Without a table everything is main memory and atomics are allowed
  localparam pma_region_t NO_PMA_R_DEFAULT = '{
    word_addr_low: 32'h0, word_addr_high: 32'h0,
    main: 1'b1, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b1
  };

  // Region table, lower index wins on overlap
  // Bounds are byte addresses shifted right by two
  localparam pma_region_t PMA_CFG [`PMA_NUM_REGIONS-1:0] = '{
    // Bytes 0x0000_1000 up to 0x0000_2000, atomic capable RAM window
    0: '{word_addr_low: 32'h0000_0400, word_addr_high: 32'h0000_0800,
         main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b1},
    // Bytes 0x0000_0000 up to 0x0001_0000, general RAM
    1: '{word_addr_low: 32'h0000_0000, word_addr_high: 32'h0000_4000,
         main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b0},
    // Bytes 0x1000_0000 up to 0x1000_1000, peripheral space
    2: '{word_addr_low: 32'h0400_0000, word_addr_high: 32'h0400_0400,
         main: 1'b0, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
    // Bytes 0x2000_0000 up to 0x2010_0000, uncached shared memory
    3: '{word_addr_low: 32'h0800_0000, word_addr_high: 32'h0804_0000,
         main: 1'b1, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b1}
  };

endpackage

// ==== rtl/pma_access_decode.sv ====
// Requester must keep atomics word-sized and never issue them as fetches. No back-pressure
module pma_access_decode (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Raw request
  input  logic                  req_valid_i,
  input  logic [31:0]           req_addr_i,
  input  pma_pkg::access_kind_e req_kind_i,
  input  pma_pkg::access_size_e req_size_i,
  input  logic                  req_atomic_i,

  // Decoded access towards execute
  output logic                  dec_valid_o,
  output pma_pkg::pma_access_t  dec_access_o
);

  import pma_pkg::*;

  pma_access_t nxt_access;
  logic        misaligned;

  //////////////////////////////
  // Alignment check
  //////////////////////////////

  // Natural alignment per size
  // Byte accesses can never be misaligned
  always_comb begin
    unique case (req_size_i)
      SIZE_HALF: misaligned = req_addr_i[0];
      SIZE_WORD: misaligned = |req_addr_i[1:0];
      default:   misaligned = 1'b0;
    endcase
  end

  //////////////////////////////
  // Access classification
  //////////////////////////////

  always_comb begin
    // Region table works on word addresses
    nxt_access.word_addr  = {2'b00, req_addr_i[31:2]};
    nxt_access.fetch      = (req_kind_i == ACC_FETCH);
    nxt_access.load       = (req_kind_i == ACC_LOAD);
    // Store is implied when neither flag is set
    nxt_access.atomic     = req_atomic_i;
    nxt_access.misaligned = misaligned;
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////

  // Valid strobe is the only control state here
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= req_valid_i;
    end
  end

  // Payload only captured for real requests
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      dec_access_o <= nxt_access;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Atomics are AMO/LR/SC only, so word data path and never from fetch
  atomic_req_legal_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (req_valid_i && req_atomic_i) |-> ((req_kind_i != ACC_FETCH) && (req_size_i == SIZE_WORD))
  ) else $error("atomic request with fetch kind or non-word size");

endmodule

// ==== rtl/pma_region_check.sv ====
// Purely combinational. Region table is static and lower indices take priority on overlap
`include "pma_defs.svh"

module pma_region_check #(
  parameter int                  NUM_REGIONS = `PMA_NUM_REGIONS,
  parameter bit                  A_EXTENSION = `PMA_A_EXTENSION,
  parameter pma_pkg::pma_region_t REGION_CFG [NUM_REGIONS-1:0] = pma_pkg::PMA_CFG
) (
  input  pma_pkg::pma_access_t access_i,
  output pma_pkg::pma_attr_t   attr_o
);

  import pma_pkg::*;

  pma_region_t sel_cfg;
  logic        sel_hit;
  logic [1:0]  sel_region;
  logic        sel_atomic;

  //////////////////////////////
  // Region lookup
  //////////////////////////////

  generate
    if (NUM_REGIONS == 0) begin : gen_no_pma

      // Deconfigured build
      // No table to hit so everything is treated as main memory
      assign sel_cfg    = NO_PMA_R_DEFAULT;
      assign sel_hit    = 1'b0;
      assign sel_region = 2'd0;

    end else begin : gen_pma

      // Scan from the top down so the lowest matching index is left standing
      always_comb begin
        sel_cfg    = PMA_R_DEFAULT;
        sel_hit    = 1'b0;
        sel_region = 2'd0;
        for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
          // Low bound inclusive and high bound exclusive
          if ((access_i.word_addr >= REGION_CFG[i].word_addr_low) &&
              (access_i.word_addr <  REGION_CFG[i].word_addr_high)) begin
            sel_cfg    = REGION_CFG[i];
            sel_hit    = 1'b1;
            sel_region = 2'(i);
          end
        end
      end

    end
  endgenerate

  //////////////////////////////
  // Atomic support
  //////////////////////////////

  // Without the A extension no region may accept atomics
  generate
    if (A_EXTENSION) begin : gen_atomic
      assign sel_atomic = sel_cfg.atomic;
    end else begin : gen_no_atomic
      assign sel_atomic = 1'b0;
    end
  endgenerate

  //////////////////////////////
  // Legality and attributes
  //////////////////////////////

  always_comb begin
    // Atomic access needs an atomic capable region
    attr_o.err_atomic     = access_i.atomic && !sel_atomic;

    // Code can only be fetched from main memory
    attr_o.err_fetch      = access_i.fetch && !sel_cfg.main;

    // I/O space cannot take misaligned accesses
    // Main memory copes with them and splitting is handled elsewhere
    attr_o.err_misaligned = access_i.misaligned && !sel_cfg.main;

    // Only plain stores may be buffered
    attr_o.bufferable     = sel_cfg.bufferable &&
                            !access_i.fetch &&
                            !access_i.atomic &&
                            !access_i.load;

    // Cacheability is taken straight from the region
    attr_o.cacheable      = sel_cfg.cacheable;

    attr_o.hit            = sel_hit;
    attr_o.region         = sel_region;
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Reported region index must point into the table and hold the address
  // A region index too wide for the field would land on the wrong entry here
  always_comb begin
    if (attr_o.hit) begin
      hit_region_in_table_a: assert ((int'(attr_o.region) < NUM_REGIONS) &&
          (access_i.word_addr >= REGION_CFG[attr_o.region].word_addr_low) &&
          (access_i.word_addr <  REGION_CFG[attr_o.region].word_addr_high))
        else $error("hit region %0d outside table or not holding the address", attr_o.region);
    end
  end

endmodule

// ==== rtl/pma_result.sv ====
// Response is emitted without back-pressure. Fault counter sticks at all ones
`include "pma_defs.svh"

module pma_result (
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // From execute stage
  input  logic                     valid_i,
  input  pma_pkg::pma_attr_t       attr_i,

  // Registered response
  output logic                     rsp_valid_o,
  output pma_pkg::pma_rsp_t        rsp_o,
  output logic [`PMA_ERR_CNT_W-1:0] err_count_o
);

  import pma_pkg::*;

  pma_rsp_t nxt_rsp;

  //////////////////////////////
  // Cause encoding
  //////////////////////////////

  always_comb begin
    nxt_rsp.err = attr_i.err_atomic | attr_i.err_fetch | attr_i.err_misaligned;

    // Atomic first, then fetch, then misaligned
    if (attr_i.err_atomic) begin
      nxt_rsp.cause = CAUSE_ATOMIC;
    end else if (attr_i.err_fetch) begin
      nxt_rsp.cause = CAUSE_FETCH;
    end else if (attr_i.err_misaligned) begin
      nxt_rsp.cause = CAUSE_MISALIGNED;
    end else begin
      nxt_rsp.cause = CAUSE_NONE;
    end

    nxt_rsp.bufferable = attr_i.bufferable;
    nxt_rsp.cacheable  = attr_i.cacheable;
    nxt_rsp.hit        = attr_i.hit;
    nxt_rsp.region     = attr_i.region;
  end

  //////////////////////////////
  // Response register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_o <= nxt_rsp;
    end
  end

  // Counter updates on the same edge as the faulting response appears
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      err_count_o <= '0;
    end else if (valid_i && nxt_rsp.err && (err_count_o != '1)) begin
      err_count_o <= err_count_o + 1'b1;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Error flag and cause must never disagree on a live response
  err_matches_cause_a: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o |-> (rsp_o.err == (rsp_o.cause != CAUSE_NONE))
  ) else $error("response err flag does not match cause");

endmodule

// ==== rtl/pma_checker_top.sv ====
// Fixed two-cycle latency, one request per cycle, no stall path
`include "pma_defs.svh"

module pma_checker_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // Request
  input  logic                      req_valid_i,
  input  logic [31:0]               req_addr_i,
  input  pma_pkg::access_kind_e     req_kind_i,
  input  pma_pkg::access_size_e     req_size_i,
  input  logic                      req_atomic_i,

  // Response
  output logic                      rsp_valid_o,
  output pma_pkg::pma_rsp_t         rsp_o,
  output logic [`PMA_ERR_CNT_W-1:0] err_count_o
);

  import pma_pkg::*;

  //////////////////////////////
  // Stage wiring
  //////////////////////////////

  // Decode to execute
  logic        dec_valid;
  pma_access_t dec_access;

  // Execute to result, not registered
  pma_attr_t   exe_attr;

  // Cycle one, alignment and kind decode
  pma_access_decode pma_access_decode_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_kind_i   (req_kind_i),
    .req_size_i   (req_size_i),
    .req_atomic_i (req_atomic_i),
    .dec_valid_o  (dec_valid),
    .dec_access_o (dec_access)
  );

  // Same cycle as result input, region match and legality
  pma_region_check #(
    .NUM_REGIONS (`PMA_NUM_REGIONS),
    .A_EXTENSION (`PMA_A_EXTENSION),
    .REGION_CFG  (PMA_CFG)
  ) pma_region_check_i (
    .access_i (dec_access),
    .attr_o   (exe_attr)
  );

  // Cycle two, cause encode and fault count
  pma_result pma_result_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (dec_valid),
    .attr_i      (exe_attr),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .err_count_o (err_count_o)
  );

endmodule

// ==== dv/pma_checker_tb.sv ====
// Assumes the default four-region map with atomics enabled. Stops at the first mismatch
`include "pma_defs.svh"

module pma_checker_tb;

  import pma_pkg::*;

  //////////////////////////////
  // Run sizing
  //////////////////////////////

  localparam int RESET_CYCLES   = 3;
  localparam int NUM_ROWS       = 25;
  localparam int NUM_RAND       = 40;
  // Faulting requests enough to push the fault counter into saturation
  localparam int NUM_SAT        = 1 << `PMA_ERR_CNT_W;
  // Every random request may bring one idle cycle with it
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS + 2 * NUM_RAND + NUM_SAT + 20;

  // Stimulus with its expected response
  typedef struct packed {
    logic [31:0]  addr;
    access_kind_e kind;
    access_size_e size;
    logic         atomic;
    logic         err;
    pma_cause_e   cause;
    logic         hit;
    logic [1:0]   region;
    logic         bufferable;
    logic         cacheable;
  } row_t;

  // Outstanding request and the cycle its response is due
  typedef struct packed {
    row_t row;
    int   due;
  } exp_t;

  // Memory map by byte address
  // Bit i of each mask belongs to region i
  localparam logic [31:0] R_LOW  [4] = '{32'h0000_1000, 32'h0000_0000,
                                          32'h1000_0000, 32'h2000_0000};
  localparam logic [31:0] R_HIGH [4] = '{32'h0000_2000, 32'h0001_0000,
                                          32'h1000_1000, 32'h2010_0000};
  localparam logic [3:0]  R_MAIN   = 4'b1011;
  localparam logic [3:0]  R_BUF    = 4'b0110;
  localparam logic [3:0]  R_CACHE  = 4'b0011;
  localparam logic [3:0]  R_ATOMIC = 4'b1001;

  localparam row_t IDLE_ROW = '{32'h0, ACC_LOAD, SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,
                                1'b0, 2'd0, 1'b0, 1'b0};

  // addr, kind, size, atomic, err, cause, hit, region, bufferable, cacheable
  localparam row_t ROWS [NUM_ROWS] = '{
    // Overlap of region 0 and 1 resolves to 0
    '{32'h0000_1004, ACC_LOAD,  SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd0, 1'b0, 1'b1},
    '{32'h0000_1008, ACC_STORE, SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd0, 1'b0, 1'b1},
    '{32'h0000_0100, ACC_STORE, SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd1, 1'b1, 1'b1},
    '{32'h0000_0100, ACC_LOAD,  SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd1, 1'b0, 1'b1},
    '{32'h0000_0200, ACC_FETCH, SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd1, 1'b0, 1'b1},
    // Outside every region
    '{32'h3000_0000, ACC_LOAD,  SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b0, 2'd0, 1'b0, 1'b0},
    // Fault causes
    '{32'h0000_0104, ACC_STORE, SIZE_WORD, 1'b1, 1'b1, CAUSE_ATOMIC,     1'b1, 2'd1, 1'b0, 1'b1},
    '{32'h1000_0010, ACC_FETCH, SIZE_WORD, 1'b0, 1'b1, CAUSE_FETCH,      1'b1, 2'd2, 1'b0, 1'b0},
    '{32'h1000_0012, ACC_STORE, SIZE_WORD, 1'b0, 1'b1, CAUSE_MISALIGNED, 1'b1, 2'd2, 1'b1, 1'b0},
    '{32'h1000_0011, ACC_STORE, SIZE_WORD, 1'b1, 1'b1, CAUSE_ATOMIC,     1'b1, 2'd2, 1'b0, 1'b0},
    // Bufferable only for plain stores
    '{32'h1000_0020, ACC_STORE, SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd2, 1'b1, 1'b0},
    '{32'h1000_0020, ACC_LOAD,  SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd2, 1'b0, 1'b0},
    // Alignment rule per size
    '{32'h1000_0021, ACC_STORE, SIZE_BYTE, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd2, 1'b1, 1'b0},
    '{32'h1000_0023, ACC_LOAD,  SIZE_BYTE, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd2, 1'b0, 1'b0},
    '{32'h1000_0031, ACC_LOAD,  SIZE_HALF, 1'b0, 1'b1, CAUSE_MISALIGNED, 1'b1, 2'd2, 1'b0, 1'b0},
    '{32'h1000_0032, ACC_STORE, SIZE_HALF, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd2, 1'b1, 1'b0},
    '{32'h0000_0103, ACC_LOAD,  SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd1, 1'b0, 1'b1},
    '{32'h2000_0101, ACC_STORE, SIZE_HALF, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd3, 1'b0, 1'b0},
    '{32'h2000_0040, ACC_STORE, SIZE_WORD, 1'b1, 1'b0, CAUSE_NONE,       1'b1, 2'd3, 1'b0, 1'b0},
    // Region edges with an exclusive high bound
    '{32'h1000_1000, ACC_LOAD,  SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b0, 2'd0, 1'b0, 1'b0},
    '{32'h0000_1ffc, ACC_STORE, SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd0, 1'b0, 1'b1},
    '{32'h0000_2000, ACC_STORE, SIZE_WORD, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd1, 1'b1, 1'b1},
    '{32'h2000_0002, ACC_FETCH, SIZE_HALF, 1'b0, 1'b0, CAUSE_NONE,       1'b1, 2'd3, 1'b0, 1'b0},
    // Default attributes are non-main
    '{32'h4000_0001, ACC_LOAD,  SIZE_HALF, 1'b0, 1'b1, CAUSE_MISALIGNED, 1'b0, 2'd0, 1'b0, 1'b0},
    '{32'h4000_0000, ACC_FETCH, SIZE_WORD, 1'b0, 1'b1, CAUSE_FETCH,      1'b0, 2'd0, 1'b0, 1'b0}
  };

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      req_valid_i;
  logic [31:0]               req_addr_i;
  access_kind_e              req_kind_i;
  access_size_e              req_size_i;
  logic                      req_atomic_i;
  logic                      rsp_valid_o;
  pma_rsp_t                  rsp_o;
  logic [`PMA_ERR_CNT_W-1:0] err_count_o;

  exp_t                      exp_q [$];
  logic [`PMA_ERR_CNT_W-1:0] exp_err_count = '0;
  int                        cyc = 0;

  pma_checker_top pma_checker_top_i (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .req_kind_i   (req_kind_i),
    .req_size_i   (req_size_i),
    .req_atomic_i (req_atomic_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .err_count_o  (err_count_o)
  );

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    forever begin
      @(posedge clk_i);
      cyc++;
      if (cyc > TIMEOUT_CYCLES) begin
        fail_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
      end
    end
  end

  //////////////////////////////
  // Reporting
  //////////////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Lowest matching region wins
  // Misses take the non-main defaults
  function automatic row_t expect_row(input logic [31:0] addr, input access_kind_e kind,
                                      input access_size_e size, input logic atomic);
    row_t r;
    logic main;
    logic region_buf;
    logic atomic_ok;
    logic mis;
    r            = IDLE_ROW;
    r.addr       = addr;
    r.kind       = kind;
    r.size       = size;
    r.atomic     = atomic;
    main         = 1'b0;
    region_buf   = 1'b0;
    atomic_ok    = 1'b0;
    for (int i = 3; i >= 0; i--) begin
      if ((addr >= R_LOW[i]) && (addr < R_HIGH[i])) begin
        r.hit       = 1'b1;
        r.region    = 2'(i);
        main        = R_MAIN[i];
        region_buf  = R_BUF[i];
        r.cacheable = R_CACHE[i];
        atomic_ok   = R_ATOMIC[i];
      end
    end
    mis = ((size == SIZE_HALF) && addr[0]) || ((size == SIZE_WORD) && (addr[1:0] != 2'b00));
    // Cause priority is atomic, fetch, misaligned
    if (atomic && !atomic_ok) begin
      r.cause = CAUSE_ATOMIC;
    end else if ((kind == ACC_FETCH) && !main) begin
      r.cause = CAUSE_FETCH;
    end else if (mis && !main) begin
      r.cause = CAUSE_MISALIGNED;
    end else begin
      r.cause = CAUSE_NONE;
    end
    r.err        = (r.cause != CAUSE_NONE);
    r.bufferable = region_buf && (kind == ACC_STORE) && !atomic;
    return r;
  endfunction

  // Atomics only as word loads or stores
  function automatic row_t random_row();
    logic [31:0]  addr;
    access_kind_e kind;
    access_size_e size;
    logic         atomic;
    case ($urandom_range(0, 4))
      0:       addr = 32'h0000_1000 + $urandom_range(0, 32'hfff);
      1:       addr = $urandom_range(0, 32'hffff);
      2:       addr = 32'h1000_0000 + $urandom_range(0, 32'h1fff);
      3:       addr = 32'h2000_0000 + $urandom_range(0, 32'hfffff);
      default: addr = $urandom();
    endcase
    kind   = access_kind_e'(2'($urandom_range(0, 2)));
    size   = access_size_e'(2'($urandom_range(0, 2)));
    atomic = 1'b0;
    if ((kind != ACC_FETCH) && ($urandom_range(0, 3) == 0)) begin
      atomic = 1'b1;
      size   = SIZE_WORD;
    end
    return expect_row(addr, kind, size, atomic);
  endfunction

  //////////////////////////////
  // Per-cycle checking
  //////////////////////////////

  task automatic check_outputs();
    exp_t e;
    if (rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        fail_run("A response came out with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        if (e.due != cyc) begin
          fail_run($sformatf("Response for address %h came at cycle %0d, not cycle %0d",
                             e.row.addr, cyc, e.due));
        end
        check_value("rsp_o.err", 32'(rsp_o.err), 32'(e.row.err));
        check_value("rsp_o.cause", 32'(rsp_o.cause), 32'(e.row.cause));
        check_value("rsp_o.hit", 32'(rsp_o.hit), 32'(e.row.hit));
        // Region index only means something on a hit
        if (e.row.hit) begin
          check_value("rsp_o.region", 32'(rsp_o.region), 32'(e.row.region));
        end
        check_value("rsp_o.bufferable", 32'(rsp_o.bufferable), 32'(e.row.bufferable));
        check_value("rsp_o.cacheable", 32'(rsp_o.cacheable), 32'(e.row.cacheable));
        if (e.row.err && (exp_err_count != {`PMA_ERR_CNT_W{1'b1}})) begin
          exp_err_count++;
        end
      end
    end else if ((exp_q.size() != 0) && (exp_q[0].due == cyc)) begin
      fail_run($sformatf("No response for address %h at cycle %0d", exp_q[0].row.addr, cyc));
    end
    check_value("err_count_o", 32'(err_count_o), 32'(exp_err_count));
  endtask

  // One cycle that checks first and then drives
  task automatic step(input logic valid, input row_t row);
    exp_t e;
    @(posedge clk_i);
    #2;
    check_outputs();
    req_valid_i  = valid;
    req_addr_i   = row.addr;
    req_kind_i   = row.kind;
    req_size_i   = row.size;
    req_atomic_i = row.atomic;
    if (valid) begin
      e.row = row;
      e.due = cyc + 2;
      exp_q.push_back(e);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    void'($urandom(83729));
    arst_n_i     = 1'b0;
    req_valid_i  = 1'b0;
    req_addr_i   = 32'h0;
    req_kind_i   = ACC_LOAD;
    req_size_i   = SIZE_WORD;
    req_atomic_i = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    check_value("err_count_o", 32'(err_count_o), 32'h0);

    // Directed rows back to back
    for (int i = 0; i < NUM_ROWS; i++) begin
      step(1'b1, ROWS[i]);
    end

    // Random requests with occasional gaps
    for (int i = 0; i < NUM_RAND; i++) begin
      if ($urandom_range(0, 3) == 0) begin
        step(1'b0, IDLE_ROW);
      end
      step(1'b1, random_row());
    end

    // Fetches from unmapped space until the fault counter sticks at its maximum
    for (int i = 0; i < NUM_SAT; i++) begin
      step(1'b1, expect_row(32'h4000_0000, ACC_FETCH, SIZE_WORD, 1'b0));
    end

    // Drain and add one idle cycle to catch stray responses
    while (exp_q.size() != 0) begin
      step(1'b0, IDLE_ROW);
    end
    step(1'b0, IDLE_ROW);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== pma_checker_top.f ====
+incdir+rtl
rtl/pma_pkg.sv
rtl/pma_access_decode.sv
rtl/pma_region_check.sv
rtl/pma_result.sv
rtl/pma_checker_top.sv
dv/pma_checker_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PMA checker testbench with Verilator

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -f pma_checker_top.f \
  --top-module pma_checker_tb -o pma_sim > "$BUILD_LOG" 2>&1 \
  || { echo "Build failed, see $BUILD_LOG"; exit 1; }

./obj_dir/pma_sim > "$SIM_LOG" 2>&1

grep -qF '*** TEST FAILED ***' "$SIM_LOG" && { echo "Simulation failed, see $SIM_LOG"; exit 1; }
grep -qF '*** TEST PASSED ***' "$SIM_LOG" || { echo "Simulation gave no result, see $SIM_LOG"; exit 1; }

echo "Simulation passed"
exit 0
